// File: src/cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// 16-bit lanes per burst line
`define BURST_LEN 4

// entries in the command and result FIFOs
`define FIFO_DEPTH 64

// host block size in 32-bit words
`define BLOCK_SIZE 16

// slack for the registered count in the throttle
`define BUFFER_HEADROOM 4

// line RAM address widths
`define D_RAM_AW 6
`define W_RAM_AW 8

`endif

// File: src/cnn_pkg.sv
`include "cnn_cfg.svh"

package cnn_pkg;

	typedef logic signed [15:0] lane_t;

	// lane 0 holds the earliest sample of the burst
	typedef lane_t [`BURST_LEN-1:0] line_t;

	typedef struct packed {
		logic [2:0]  op_type;
		logic [3:0]  stride;
		logic [7:0]  kernel;
		logic [7:0]  i_side;
		logic [7:0]  o_side;
		logic [15:0] i_channel;
		logic [15:0] o_channel;
		logic [7:0]  padding;
		logic [7:0]  kernel_size;
		logic [15:0] stride2;
	} layer_cfg_t;

	typedef struct packed {
		logic signed [31:0] value;
		logic               last;   // final output channel of the run
	} result_t;

	typedef enum logic [2:0] {
		CSB_IDLE,
		CSB_WORD0,
		CSB_WORD1,
		CSB_WORD2,
		CSB_DONE
	} csb_state_t;

	localparam logic [2:0] OP_GEMM = 3'd1;

endpackage

// File: src/pipe_fifo.sv
`include "cnn_cfg.svh"

module pipe_fifo #(
	parameter type T     = logic [31:0],
	parameter int  DEPTH = `FIFO_DEPTH
) (
	input  logic                       okClk,
	input  logic                       i_rst,
	input  logic                       i_write,
	input  T                           i_wdata,
	input  logic                       i_read,
	output T                           o_rdata,
	output logic                       o_empty,
	output logic                       o_full,
	output logic [$clog2(DEPTH+1)-1:0] o_count
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH+1);

	T              mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_write;
	logic          do_read;

	assign o_empty = (count == '0);
	assign o_full  = (count == CW'(DEPTH));
	assign o_count = count;

	assign do_write = i_write && !o_full;   // writes to a full FIFO are lost
	assign do_read  = i_read && !o_empty;

	// head is visible before the pop
	assign o_rdata = mem[rd_ptr];

	always_ff @(posedge okClk) begin
		if (do_write)
			mem[wr_ptr] <= i_wdata;
	end

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write)
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

endmodule

// File: src/burst_packer.sv
`include "cnn_cfg.svh"

module burst_packer
	import cnn_pkg::*;
#(
	parameter int AW = 6
) (
	input  logic          okClk,
	input  logic          i_rst,
	input  logic          i_write,
	input  logic [15:0]   i_sample,
	output logic          o_ram_we,
	output logic [AW-1:0] o_ram_addr,
	output line_t         o_ram_line
);

	localparam int CW = $clog2(`BURST_LEN);

	logic [CW-1:0] lane_cnt;
	line_t         line_q;

	assign o_ram_line = line_q;

	// new sample enters at the top, older ones move toward lane 0
	always_ff @(posedge okClk) begin
		if (i_write)
			line_q <= {i_sample, line_q[`BURST_LEN-1:1]};
	end

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			lane_cnt   <= '0;
			o_ram_we   <= 1'b0;
			o_ram_addr <= '0;
		end else begin
			o_ram_we <= 1'b0;
			if (i_write) begin
				if (lane_cnt == CW'(`BURST_LEN-1)) begin
					lane_cnt <= '0;
					o_ram_we <= 1'b1;   // line is complete on the next cycle
				end else begin
					lane_cnt <= lane_cnt + 1'b1;
				end
			end
			// post-increment once the line has gone out
			if (o_ram_we)
				o_ram_addr <= o_ram_addr + 1'b1;
		end
	end

endmodule

// File: src/line_ram.sv
module line_ram
	import cnn_pkg::*;
#(
	parameter int AW = 6
) (
	input  logic          okClk,
	input  logic          i_we,
	input  logic [AW-1:0] i_waddr,
	input  line_t         i_wline,
	input  logic [AW-1:0] i_raddr,
	output line_t         o_rline
);

	line_t mem [2**AW];

	always_ff @(posedge okClk) begin
		if (i_we)
			mem[i_waddr] <= i_wline;
		o_rline <= mem[i_raddr];   // one cycle read latency
	end

endmodule

// File: src/csb.sv
module csb
	import cnn_pkg::*;
(
	input  logic        okClk,
	input  logic        i_rst,
	input  logic        i_op_en,
	input  logic        i_fifo_empty,
	input  logic [31:0] i_fifo_data,
	output logic        o_fifo_read,
	output layer_cfg_t  o_cfg,
	output csb_state_t  o_state
);

	csb_state_t state;
	csb_state_t state_next;
	logic       in_word;

	assign o_state = state;

	assign in_word = (state == CSB_WORD0) || (state == CSB_WORD1) ||
	                 (state == CSB_WORD2);

	// head of the FWFT FIFO is taken in the same cycle as the pop
	assign o_fifo_read = in_word && !i_fifo_empty;

	always_comb begin
		state_next = state;
		case (state)
			CSB_IDLE:  if (i_op_en) state_next = CSB_WORD0;
			CSB_WORD0: if (!i_fifo_empty) state_next = CSB_WORD1;
			CSB_WORD1: if (!i_fifo_empty) state_next = CSB_WORD2;
			CSB_WORD2: if (!i_fifo_empty) state_next = CSB_DONE;
			CSB_DONE:  state_next = CSB_IDLE;
			default:   state_next = CSB_IDLE;
		endcase
	end

	always_ff @(posedge okClk) begin
		if (i_rst)
			state <= CSB_IDLE;
		else
			state <= state_next;
	end

	// field decode, held until the next command
	always_ff @(posedge okClk) begin
		if (i_rst) begin
			o_cfg <= '0;
		end else if (o_fifo_read) begin
			case (state)
				CSB_WORD0: begin
					o_cfg.o_side  <= i_fifo_data[31:24];
					o_cfg.i_side  <= i_fifo_data[23:16];
					o_cfg.kernel  <= i_fifo_data[15:8];
					o_cfg.stride  <= i_fifo_data[7:4];
					o_cfg.op_type <= i_fifo_data[2:0];   // bit 3 is spare
				end
				CSB_WORD1: begin
					o_cfg.o_channel <= i_fifo_data[31:16];
					o_cfg.i_channel <= i_fifo_data[15:0];
				end
				CSB_WORD2: begin
					o_cfg.stride2     <= i_fifo_data[31:16];
					o_cfg.kernel_size <= i_fifo_data[15:8];
					o_cfg.padding     <= i_fifo_data[7:0];
				end
				default: o_cfg <= o_cfg;
			endcase
		end
	end

endmodule

// File: src/gemm_engine.sv
`include "cnn_cfg.svh"

module gemm_engine
	import cnn_pkg::*;
(
	input  logic                                 okClk,
	input  logic                                 i_rst,
	input  logic                                 i_start,
	input  layer_cfg_t                           i_cfg,
	input  line_t                                i_d_line,
	input  line_t                                i_w_line,
	output logic [`D_RAM_AW-1:0]                 o_d_addr,
	output logic [`W_RAM_AW-1:0]                 o_w_addr,
	input  logic [$clog2(`FIFO_DEPTH+1)-1:0]     i_result_count,
	output logic                                 o_result_write,
	output result_t                              o_result,
	output logic                                 o_busy,
	output logic                                 o_finish,
	output logic [31:0]                          o_timer
);

	localparam int CW = $clog2(`FIFO_DEPTH+1);

	logic [15:0]          ic;
	logic [15:0]          oc;
	logic [15:0]          k;
	logic [15:0]          o;
	logic [`W_RAM_AW-1:0] w_addr;
	logic                 issuing;
	logic                 stall;
	logic                 fire;
	logic                 k_last;
	logic                 o_last;
	logic                 cfg_ok;

	// tags follow the read through the RAM and product stages
	logic                 v1, kl1, ol1;
	logic                 v2, kl2, ol2;

	logic signed [31:0]   prod [`BURST_LEN];
	logic signed [31:0]   tree_sum;
	logic signed [31:0]   acc;
	logic signed [31:0]   acc_sum;

	assign cfg_ok = (i_cfg.op_type == OP_GEMM) && (i_cfg.i_channel != '0) &&
	                (i_cfg.o_channel != '0);

	// hold off while the result FIFO is nearly full
	assign stall  = (i_result_count >= CW'(`FIFO_DEPTH-2));
	assign fire   = issuing && !stall;
	assign k_last = (k == ic - 1'b1);
	assign o_last = (o == oc - 1'b1);

	assign o_d_addr = k[`D_RAM_AW-1:0];
	assign o_w_addr = w_addr;   // o * ic + k, walked in order

	// read address generation
	always_ff @(posedge okClk) begin
		if (i_rst) begin
			issuing <= 1'b0;
			k       <= '0;
			o       <= '0;
			w_addr  <= '0;
			ic      <= '0;
			oc      <= '0;
		end else if (i_start) begin
			issuing <= cfg_ok;
			k       <= '0;
			o       <= '0;
			w_addr  <= '0;
			ic      <= i_cfg.i_channel;
			oc      <= i_cfg.o_channel;
		end else if (fire) begin
			w_addr <= w_addr + 1'b1;
			if (k_last) begin
				k <= '0;
				if (o_last)
					issuing <= 1'b0;   // all reads sent
				else
					o <= o + 1'b1;
			end else begin
				k <= k + 1'b1;
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			v1  <= 1'b0;
			kl1 <= 1'b0;
			ol1 <= 1'b0;
			v2  <= 1'b0;
			kl2 <= 1'b0;
			ol2 <= 1'b0;
		end else begin
			v1  <= fire;
			kl1 <= fire && k_last;
			ol1 <= fire && o_last;
			v2  <= v1;
			kl2 <= kl1;
			ol2 <= ol1;
		end
	end

	// lane products, one register stage after the RAM
	always_ff @(posedge okClk) begin
		for (int l = 0; l < `BURST_LEN; l++)
			prod[l] <= i_d_line[l] * i_w_line[l];
	end

	always_comb begin
		tree_sum = '0;
		for (int l = 0; l < `BURST_LEN; l++)
			tree_sum = tree_sum + prod[l];
	end

	assign acc_sum = acc + tree_sum;   // wraps at 32 bits

	always_ff @(posedge okClk) begin
		if (i_rst || i_start)
			acc <= '0;
		else if (v2)
			acc <= kl2 ? '0 : acc_sum;   // restart after each output
	end

	assign o_result_write = v2 && kl2;
	assign o_result.value = acc_sum;
	assign o_result.last  = ol2;

	// run status and timer
	always_ff @(posedge okClk) begin
		if (i_rst) begin
			o_busy   <= 1'b0;
			o_finish <= 1'b0;
			o_timer  <= '0;
		end else if (i_start) begin
			o_busy   <= cfg_ok;
			o_finish <= !cfg_ok;   // nothing to do
			o_timer  <= '0;
		end else begin
			if (o_busy)
				o_timer <= o_timer + 1'b1;
			if (o_result_write && ol2) begin
				o_busy   <= 1'b0;
				o_finish <= 1'b1;
			end
		end
	end

endmodule

// File: src/accel_top.sv
`include "cnn_cfg.svh"

module accel_top
	import cnn_pkg::*;
(
	input  logic                             okClk,
	input  logic                             i_rst,
	input  logic                             i_op_en,
	input  logic                             i_engine_valid,
	input  logic                             i_cmd_write,
	input  logic [31:0]                      i_cmd_data,
	input  logic                             i_data_write,
	input  logic                             i_weig_write,
	input  logic [31:0]                      i_pipe_data,
	input  logic                             i_result_read,
	output logic                             o_pipe_in_ready,
	output result_t                          o_result,
	output logic                             o_result_empty,
	output logic [$clog2(`FIFO_DEPTH+1)-1:0] o_result_count,
	output layer_cfg_t                       o_cfg,
	output csb_state_t                       o_csb_state,
	output logic                             o_gemm_finish,
	output logic                             o_busy,
	output logic [31:0]                      o_timer
);

	localparam int CW = $clog2(`FIFO_DEPTH+1);
	localparam int THROTTLE_LEVEL = `FIFO_DEPTH - `BUFFER_HEADROOM - `BLOCK_SIZE;

	// command path
	logic [31:0]          cmd_head;
	logic                 cmd_empty;
	logic                 cmd_read;
	logic [CW-1:0]        cmd_count;

	// line RAM write and read sides
	logic                 d_we;
	logic [`D_RAM_AW-1:0] d_waddr;
	line_t                d_wline;
	logic [`D_RAM_AW-1:0] d_raddr;
	line_t                d_rline;
	logic                 w_we;
	logic [`W_RAM_AW-1:0] w_waddr;
	line_t                w_wline;
	logic [`W_RAM_AW-1:0] w_raddr;
	line_t                w_rline;

	// engine to result FIFO
	logic                 res_write;
	result_t              res_data;

	pipe_fifo #(.T(logic [31:0]), .DEPTH(`FIFO_DEPTH)) cmd_fifo (
		.okClk   (okClk),
		.i_rst   (i_rst),
		.i_write (i_cmd_write),
		.i_wdata (i_cmd_data),
		.i_read  (cmd_read),
		.o_rdata (cmd_head),
		.o_empty (cmd_empty),
		.o_full  (),            // overflow is dropped inside
		.o_count (cmd_count)
	);

	// block throttle, one cycle behind the count
	always_ff @(posedge okClk) begin
		if (i_rst)
			o_pipe_in_ready <= 1'b0;
		else
			o_pipe_in_ready <= (cmd_count <= CW'(THROTTLE_LEVEL));
	end

	csb u_csb (
		.okClk        (okClk),
		.i_rst        (i_rst),
		.i_op_en      (i_op_en),
		.i_fifo_empty (cmd_empty),
		.i_fifo_data  (cmd_head),
		.o_fifo_read  (cmd_read),
		.o_cfg        (o_cfg),
		.o_state      (o_csb_state)
	);

	burst_packer #(.AW(`D_RAM_AW)) d_packer (
		.okClk      (okClk),
		.i_rst      (i_rst),
		.i_write    (i_data_write),
		.i_sample   (i_pipe_data[15:0]),
		.o_ram_we   (d_we),
		.o_ram_addr (d_waddr),
		.o_ram_line (d_wline)
	);

	burst_packer #(.AW(`W_RAM_AW)) w_packer (
		.okClk      (okClk),
		.i_rst      (i_rst),
		.i_write    (i_weig_write),
		.i_sample   (i_pipe_data[15:0]),
		.o_ram_we   (w_we),
		.o_ram_addr (w_waddr),
		.o_ram_line (w_wline)
	);

	line_ram #(.AW(`D_RAM_AW)) d_ram (
		.okClk   (okClk),
		.i_we    (d_we),
		.i_waddr (d_waddr),
		.i_wline (d_wline),
		.i_raddr (d_raddr),
		.o_rline (d_rline)
	);

	line_ram #(.AW(`W_RAM_AW)) w_ram (
		.okClk   (okClk),
		.i_we    (w_we),
		.i_waddr (w_waddr),
		.i_wline (w_wline),
		.i_raddr (w_raddr),
		.o_rline (w_rline)
	);

	gemm_engine u_engine (
		.okClk          (okClk),
		.i_rst          (i_rst),
		.i_start        (i_engine_valid),
		.i_cfg          (o_cfg),
		.i_d_line       (d_rline),
		.i_w_line       (w_rline),
		.o_d_addr       (d_raddr),
		.o_w_addr       (w_raddr),
		.i_result_count (o_result_count),
		.o_result_write (res_write),
		.o_result       (res_data),
		.o_busy         (o_busy),
		.o_finish       (o_gemm_finish),
		.o_timer        (o_timer)
	);

	pipe_fifo #(.T(result_t), .DEPTH(`FIFO_DEPTH)) result_fifo (
		.okClk   (okClk),
		.i_rst   (i_rst),
		.i_write (res_write),
		.i_wdata (res_data),
		.i_read  (i_result_read),
		.o_rdata (o_result),
		.o_empty (o_result_empty),
		.o_full  (),            // engine stalls well before full
		.o_count (o_result_count)
	);

endmodule

// File: sim/tb_accel.sv
`include "cnn_cfg.svh"

module tb_accel
	import cnn_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CW         = $clog2(`FIFO_DEPTH+1);
	localparam int WAIT_LIMIT = 5000;

	logic                 okClk;
	logic                 i_rst;
	logic                 i_op_en;
	logic                 i_engine_valid;
	logic                 i_cmd_write;
	logic [31:0]          i_cmd_data;
	logic                 i_data_write;
	logic                 i_weig_write;
	logic [31:0]          i_pipe_data;
	logic                 i_result_read;
	logic                 o_pipe_in_ready;
	result_t              o_result;
	logic                 o_result_empty;
	logic [CW-1:0]        o_result_count;
	layer_cfg_t           o_cfg;
	csb_state_t           o_csb_state;
	logic                 o_gemm_finish;
	logic                 o_busy;
	logic [31:0]          o_timer;

	logic [31:0]          rng;
	int                   errors;
	int                   tests_passed;
	int                   tests_failed;

	// host samples, kept for the reference model
	logic signed [15:0]   d_samples [$];
	logic signed [15:0]   w_samples [$];
	int                   expected [$];

	accel_top u_dut (
		.okClk           (okClk),
		.i_rst           (i_rst),
		.i_op_en         (i_op_en),
		.i_engine_valid  (i_engine_valid),
		.i_cmd_write     (i_cmd_write),
		.i_cmd_data      (i_cmd_data),
		.i_data_write    (i_data_write),
		.i_weig_write    (i_weig_write),
		.i_pipe_data     (i_pipe_data),
		.i_result_read   (i_result_read),
		.o_pipe_in_ready (o_pipe_in_ready),
		.o_result        (o_result),
		.o_result_empty  (o_result_empty),
		.o_result_count  (o_result_count),
		.o_cfg           (o_cfg),
		.o_csb_state     (o_csb_state),
		.o_gemm_finish   (o_gemm_finish),
		.o_busy          (o_busy),
		.o_timer         (o_timer)
	);

	initial begin
		okClk = 1'b0;
		forever #5 okClk = ~okClk;
	end

	function logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED t=%0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic timeout_error(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic reset_dut();
		@(posedge okClk);
		i_rst <= 1'b1;
		repeat (3) @(posedge okClk);
		i_rst <= 1'b0;
		repeat (2) @(posedge okClk);   // throttle flag needs one more cycle
	endtask

	task automatic push_cmd(input logic [31:0] word);
		@(posedge okClk);
		i_cmd_write <= 1'b1;
		i_cmd_data  <= word;
		@(posedge okClk);
		i_cmd_write <= 1'b0;
	endtask

	task automatic push_sample(input logic is_weight, input logic [15:0] s);
		@(posedge okClk);
		i_pipe_data  <= {16'h0, s};
		i_data_write <= !is_weight;
		i_weig_write <= is_weight;
		@(posedge okClk);
		i_data_write <= 1'b0;
		i_weig_write <= 1'b0;
	endtask

	task automatic run_decode();
		int n;
		@(posedge okClk);
		i_op_en <= 1'b1;
		@(posedge okClk);
		i_op_en <= 1'b0;
		n = 0;
		do begin
			@(negedge okClk);
			n++;
		end while (o_csb_state == CSB_IDLE && n < WAIT_LIMIT);
		if (o_csb_state == CSB_IDLE)
			timeout_error("the decoder to leave idle");
		n = 0;
		while (o_csb_state != CSB_IDLE && n < WAIT_LIMIT) begin
			@(negedge okClk);
			n++;
		end
		if (o_csb_state != CSB_IDLE)
			timeout_error("the decoder to return to idle");
	endtask

	task automatic configure(input logic [2:0] op, input logic [15:0] ic,
	                         input logic [15:0] oc);
		push_cmd({24'h0, 4'h0, 1'b0, op});
		push_cmd({oc, ic});
		push_cmd(32'h0);
		run_decode();
	endtask

	task automatic start_engine_and_wait();
		int n;
		@(posedge okClk);
		i_engine_valid <= 1'b1;
		@(posedge okClk);
		i_engine_valid <= 1'b0;
		n = 0;
		do begin
			@(negedge okClk);
			n++;
		end while (!o_gemm_finish && n < WAIT_LIMIT);
		if (!o_gemm_finish)
			timeout_error("the engine to finish");
	endtask

	task automatic load_operands(input int ic, input int oc);
		logic [31:0] r;
		int          acc;
		d_samples.delete();
		w_samples.delete();
		expected.delete();
		for (int i = 0; i < ic * `BURST_LEN; i++) begin
			r = next_random();
			d_samples.push_back(r[15:0]);
			push_sample(1'b0, r[15:0]);
		end
		for (int i = 0; i < oc * ic * `BURST_LEN; i++) begin
			r = next_random();
			w_samples.push_back(r[15:0]);
			push_sample(1'b1, r[15:0]);
		end
		// data line k against weight line o*ic+k, lane by lane
		for (int o = 0; o < oc; o++) begin
			acc = 0;
			for (int k = 0; k < ic; k++)
				for (int l = 0; l < `BURST_LEN; l++)
					acc += int'(d_samples[k*`BURST_LEN+l]) *
					       int'(w_samples[(o*ic+k)*`BURST_LEN+l]);
			expected.push_back(acc);
		end
		repeat (2) @(posedge okClk);   // last line reaches the RAM
	endtask

	task automatic read_result(output result_t r);
		int n;
		n = 0;
		do begin
			@(negedge okClk);
			n++;
		end while (o_result_empty && n < WAIT_LIMIT);
		if (o_result_empty) begin
			timeout_error("a result");
			r = '0;
		end else begin
			r = o_result;
			@(posedge okClk);
			i_result_read <= 1'b1;
			@(posedge okClk);
			i_result_read <= 1'b0;
		end
	endtask

	task automatic test_reset_values();
		int e0;
		e0 = errors;
		reset_dut();
		@(negedge okClk);
		check_value("o_result_empty", o_result_empty, 1'b1);
		check_value("o_gemm_finish", o_gemm_finish, 1'b0);
		check_value("o_busy", o_busy, 1'b0);
		check_value("o_csb_state", o_csb_state, CSB_IDLE);
		check_value("o_pipe_in_ready", o_pipe_in_ready, 1'b1);
		finish_test("reset values", e0);
	endtask

	task automatic test_decode();
		int          e0;
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		e0 = errors;
		w0 = next_random();
		w1 = next_random();
		w2 = next_random();
		push_cmd(w0);
		push_cmd(w1);
		push_cmd(w2);
		run_decode();
		check_value("o_side", o_cfg.o_side, w0[31:24]);
		check_value("i_side", o_cfg.i_side, w0[23:16]);
		check_value("kernel", o_cfg.kernel, w0[15:8]);
		check_value("stride", o_cfg.stride, w0[7:4]);
		check_value("op_type", o_cfg.op_type, w0[2:0]);
		check_value("o_channel", o_cfg.o_channel, w1[31:16]);
		check_value("i_channel", o_cfg.i_channel, w1[15:0]);
		check_value("stride2", o_cfg.stride2, w2[31:16]);
		check_value("kernel_size", o_cfg.kernel_size, w2[15:8]);
		check_value("padding", o_cfg.padding, w2[7:0]);
		finish_test("command decode", e0);
	endtask

	task automatic test_gemm();
		int      e0;
		result_t r;
		e0 = errors;
		reset_dut();
		configure(OP_GEMM, 16'd2, 16'd3);
		load_operands(2, 3);
		start_engine_and_wait();
		if (o_timer == 32'd0) begin
			$display("FAILED t=%0t: o_timer is zero after finish", $time);
			errors++;
		end
		for (int o = 0; o < 3; o++) begin
			read_result(r);
			check_value($sformatf("result %0d", o), r.value, expected[o]);
			check_value($sformatf("last flag %0d", o), r.last, o == 2);
		end
		@(negedge okClk);
		check_value("o_result_empty after drain", o_result_empty, 1'b1);
		finish_test("gemm", e0);
	endtask

	task automatic test_backpressure();
		int      e0;
		int      n;
		result_t r;
		e0 = errors;
		reset_dut();
		configure(OP_GEMM, 16'd1, 16'd80);
		load_operands(1, 80);
		@(posedge okClk);
		i_engine_valid <= 1'b1;
		@(posedge okClk);
		i_engine_valid <= 1'b0;
		n = 0;
		do begin
			@(negedge okClk);
			n++;
		end while (o_result_count < CW'(`FIFO_DEPTH-2) && n < WAIT_LIMIT);
		if (o_result_count < CW'(`FIFO_DEPTH-2))
			timeout_error("the result FIFO to fill");
		check_value("o_gemm_finish while stalled", o_gemm_finish, 1'b0);
		for (int i = 0; i < 80; i++) begin
			@(negedge okClk);
			// finish only once all 80 results have been written
			if (o_gemm_finish && (i + int'(o_result_count)) < 80) begin
				$display("FAILED t=%0t: finish high with results still missing", $time);
				errors++;
			end
			read_result(r);
			check_value($sformatf("result %0d", i), r.value, expected[i]);
			check_value($sformatf("last flag %0d", i), r.last, i == 79);
		end
		@(negedge okClk);
		check_value("o_gemm_finish after drain", o_gemm_finish, 1'b1);
		finish_test("back-pressure", e0);
	endtask

	task automatic test_throttle();
		int e0;
		e0 = errors;
		reset_dut();
		for (int i = 0; i < 44; i++)
			push_cmd(next_random());
		@(posedge okClk);   // flag lags the count by a cycle
		@(negedge okClk);
		check_value("o_pipe_in_ready at 44 words", o_pipe_in_ready, 1'b1);
		push_cmd(next_random());
		@(posedge okClk);
		@(negedge okClk);
		check_value("o_pipe_in_ready at 45 words", o_pipe_in_ready, 1'b0);
		run_decode();       // three pops bring the count to 42
		check_value("o_pipe_in_ready at 42 words", o_pipe_in_ready, 1'b1);
		finish_test("throttle", e0);
	endtask

	task automatic test_other_op();
		int e0;
		e0 = errors;
		reset_dut();
		configure(3'd2, 16'd2, 16'd3);
		start_engine_and_wait();
		repeat (8) @(negedge okClk);   // longer than the read-to-write latency
		check_value("o_gemm_finish held", o_gemm_finish, 1'b1);
		check_value("o_result_empty", o_result_empty, 1'b1);
		check_value("o_busy", o_busy, 1'b0);
		finish_test("non-gemm op", e0);
	endtask

	initial begin
		i_rst          = 1'b1;
		i_op_en        = 1'b0;
		i_engine_valid = 1'b0;
		i_cmd_write    = 1'b0;
		i_cmd_data     = '0;
		i_data_write   = 1'b0;
		i_weig_write   = 1'b0;
		i_pipe_data    = '0;
		i_result_read  = 1'b0;
		rng            = 32'd5;
		errors         = 0;
		tests_passed   = 0;
		tests_failed   = 0;

		test_reset_values();
		test_decode();
		test_gemm();
		test_backpressure();
		test_throttle();
		test_other_op();

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+src
src/cnn_pkg.sv
src/pipe_fifo.sv
src/burst_packer.sv
src/line_ram.sv
src/csb.sv
src/gemm_engine.sv
src/accel_top.sv
sim/tb_accel.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_accel \
	&& ./obj_dir/Vtb_accel > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
